/* verilog/dcache_pkg.sv */
package dcache_pkg;

    // default geometry, 16 lines of 4 words
    localparam int def_index_bits    = 4;
    localparam int def_word_off_bits = 2;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;

    typedef enum logic [1:0] {op_none, op_read, op_write} cpu_op_t;

    typedef struct packed {
        cpu_op_t op;
        addr_t   addr;
        word_t   wdata;
        strb_t   strb;
    } cpu_req_t;

    // one read beat from memory
    typedef struct packed {
        word_t r_data;
        logic  r_valid;
        logic  r_last;
    } mem_rd_t;

    typedef enum logic [3:0] {
        st_idle, st_read_done, st_write_hit, st_write_done,
        st_wb_req, st_wb_wait, st_refill_req, st_refill_wait,
        st_fill, st_fill_done
    } ctrl_state_t;

endpackage

/* verilog/dcache_line_store.sv */
`timescale 1ns/1ns
module dcache_line_store
    import dcache_pkg::*;
#(
    parameter int  index_bits    = def_index_bits,
    parameter int  word_off_bits = def_word_off_bits,
    localparam int tag_bits      = 30 - index_bits - word_off_bits,
    localparam int line_bits     = 32 << word_off_bits,
    localparam int lines         = 1 << index_bits
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [index_bits-1:0]    index,
    input  logic                     word_we,
    input  logic [word_off_bits-1:0] word_off,
    input  word_t                    word_data,
    input  strb_t                    word_strb,
    input  logic                     fill_we,
    input  logic [tag_bits-1:0]      fill_tag,
    input  logic [line_bits-1:0]     fill_data,
    input  logic                     fill_dirty_bit,
    input  logic                     clean_we,
    output logic [tag_bits-1:0]      rd_tag,
    output logic                     rd_valid,
    output logic                     rd_dirty,
    output logic [line_bits-1:0]     rd_line
);

    logic [tag_bits-1:0]  tag_mem  [lines];
    logic [line_bits-1:0] data_mem [lines];
    logic [lines-1:0]     valid_q;
    logic [lines-1:0]     dirty_q;

    assign rd_tag   = tag_mem[index];
    assign rd_line  = data_mem[index];
    assign rd_valid = valid_q[index];
    assign rd_dirty = dirty_q[index];

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[index]  <= fill_tag;
            data_mem[index] <= fill_data;
        end else if (word_we) begin
            for (int b = 0; b < 4; b++) begin
                if (word_strb[b]) begin
                    data_mem[index][{word_off, 5'd0} + 8 * b +: 8] <= word_data[8 * b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_we) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= fill_dirty_bit;
        end else if (word_we) begin
            dirty_q[index] <= 1'b1;
        end else if (clean_we) begin
            dirty_q[index] <= 1'b0;
        end
    end

    a_one_write: assert property (@(posedge clk) disable iff (!resetn)
        !(word_we && fill_we));

endmodule

/* verilog/line_burst_port.sv */
`timescale 1ns/1ns
module line_burst_port
    import dcache_pkg::*;
#(
    parameter int  word_off_bits = def_word_off_bits,
    localparam int words         = 1 << word_off_bits,
    localparam int line_bits     = 32 * words
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     refill_start,
    input  logic                     wb_start,
    input  addr_t                    line_addr,
    input  logic [line_bits-1:0]     wb_line,
    input  logic                     merge_en,
    input  logic [word_off_bits-1:0] merge_off,
    input  word_t                    merge_data,
    input  strb_t                    merge_strb,
    input  logic                     ar_ready,
    input  logic                     aw_ready,
    input  mem_rd_t                  rd,
    input  logic                     b_valid,
    output addr_t                    ar_addr,
    output logic                     ar_valid,
    output addr_t                    aw_addr,
    output logic                     aw_valid,
    output word_t                    w_data,
    output logic                     w_valid,
    output logic                     w_last,
    output logic                     refill_done,
    output logic [line_bits-1:0]     fill_line,
    output logic                     fill_dirty,
    output logic                     wb_done
);

    logic [word_off_bits-1:0] rd_cnt;
    logic [word_off_bits-1:0] wr_cnt;
    logic                     merge_en_q;
    logic [word_off_bits-1:0] merge_off_q;
    word_t                    merge_data_q;
    strb_t                    merge_strb_q;
    logic                     merge_hit;
    word_t                    beat_word;
    logic                     wait_b;

    assign merge_hit = merge_en_q && (rd_cnt == merge_off_q);

    // pending store bytes replace the memory bytes
    always_comb begin
        beat_word = rd.r_data;
        if (merge_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (merge_strb_q[b]) begin
                    beat_word[8 * b +: 8] = merge_data_q[8 * b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start) begin
            ar_addr      <= line_addr;
            merge_en_q   <= merge_en;
            merge_off_q  <= merge_off;
            merge_data_q <= merge_data;
            merge_strb_q <= merge_strb;
        end
        if (wb_start) begin
            aw_addr <= line_addr;
        end
        if (rd.r_valid) begin
            fill_line[{rd_cnt, 5'd0} +: 32] <= beat_word;
        end
    end

    // refill side
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ar_valid    <= 1'b0;
            rd_cnt      <= '0;
            fill_dirty  <= 1'b0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= 1'b0;
            if (refill_start) begin
                ar_valid   <= 1'b1;
                rd_cnt     <= '0;
                fill_dirty <= 1'b0;
            end else if (ar_valid && ar_ready) begin
                ar_valid <= 1'b0;
            end
            if (rd.r_valid) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (merge_hit) begin
                    fill_dirty <= 1'b1;
                end
                if (rd.r_last) begin
                    refill_done <= 1'b1;
                end
            end
        end
    end

    // writeback streams the victim, one beat per cycle
    assign w_data = wb_line[{wr_cnt, 5'd0} +: 32];
    assign w_last = w_valid && (&wr_cnt);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            wr_cnt   <= '0;
            wait_b   <= 1'b0;
            wb_done  <= 1'b0;
        end else begin
            wb_done <= 1'b0;
            if (wb_start) begin
                aw_valid <= 1'b1;
            end else if (aw_valid && aw_ready) begin
                aw_valid <= 1'b0;
                w_valid  <= 1'b1;
                wr_cnt   <= '0;
            end
            if (w_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (&wr_cnt) begin
                    w_valid <= 1'b0;
                    wait_b  <= 1'b1;
                end
            end
            if (wait_b && b_valid) begin
                wait_b  <= 1'b0;
                wb_done <= 1'b1;
            end
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!resetn)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr)));

    a_r_last: assert property (@(posedge clk) disable iff (!resetn)
        rd.r_valid |-> (rd.r_last == (&rd_cnt)));

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ns
module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int  index_bits    = def_index_bits,
    parameter int  word_off_bits = def_word_off_bits,
    localparam int tag_bits      = 30 - index_bits - word_off_bits,
    localparam int line_bits     = 32 << word_off_bits
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  cpu_req_t                 req,
    output logic                     stall,
    output word_t                    rdata,
    input  logic [tag_bits-1:0]      rd_tag,
    input  logic                     rd_valid,
    input  logic                     rd_dirty,
    input  logic [line_bits-1:0]     rd_line,
    output logic [index_bits-1:0]    index,
    output logic                     word_we,
    output logic [word_off_bits-1:0] word_off,
    output word_t                    word_data,
    output strb_t                    word_strb,
    output logic                     fill_we,
    output logic [tag_bits-1:0]      fill_tag,
    output logic [line_bits-1:0]     fill_data,
    output logic                     fill_dirty_bit,
    output logic                     clean_we,
    input  logic                     refill_done,
    input  logic [line_bits-1:0]     fill_line,
    input  logic                     fill_dirty,
    input  logic                     wb_done,
    output logic                     refill_start,
    output logic                     wb_start,
    output addr_t                    line_addr,
    output logic                     merge_en,
    output logic [word_off_bits-1:0] merge_off,
    output word_t                    merge_data,
    output strb_t                    merge_strb
);

    ctrl_state_t          state;
    ctrl_state_t          next_state;
    logic [tag_bits-1:0]  tag;
    logic                 hit;
    logic [line_bits-1:0] fill_buf;
    logic                 fill_dirty_q;

    assign tag      = req.addr[31 -: tag_bits];
    assign index    = req.addr[word_off_bits + 2 +: index_bits];
    assign word_off = req.addr[2 +: word_off_bits];
    assign hit      = rd_valid && (rd_tag == tag);

    assign word_data      = req.wdata;
    assign word_strb      = req.strb;
    assign fill_tag       = tag;
    assign fill_data      = fill_buf;
    assign fill_dirty_bit = fill_dirty_q;

    // store merge travels with the refill command
    assign merge_en   = (req.op == op_write);
    assign merge_off  = word_off;
    assign merge_data = req.wdata;
    assign merge_strb = req.strb;

    // victim address during writeback, request line otherwise
    assign line_addr = (state == st_wb_req) ?
                       {rd_tag, index, {(word_off_bits + 2){1'b0}}} :
                       {tag, index, {(word_off_bits + 2){1'b0}}};

    always_comb begin
        next_state   = state;
        stall        = 1'b1;
        rdata        = '0;
        word_we      = 1'b0;
        fill_we      = 1'b0;
        clean_we     = 1'b0;
        wb_start     = 1'b0;
        refill_start = 1'b0;
        case (state)
            st_idle: begin
                stall = (req.op != op_none);
                if (req.op != op_none) begin
                    if (hit) begin
                        next_state = (req.op == op_write) ? st_write_hit : st_read_done;
                    end else if (rd_valid && rd_dirty) begin
                        next_state = st_wb_req;
                    end else begin
                        next_state = st_refill_req;
                    end
                end
            end
            st_read_done, st_fill_done: begin
                stall      = 1'b0;
                rdata      = rd_line[{word_off, 5'd0} +: 32];
                next_state = st_idle;
            end
            st_write_hit: begin
                word_we    = 1'b1;
                next_state = st_write_done;
            end
            st_write_done: begin
                stall      = 1'b0;
                next_state = st_idle;
            end
            st_wb_req: begin
                wb_start   = 1'b1;
                next_state = st_wb_wait;
            end
            st_wb_wait: begin
                if (wb_done) begin
                    clean_we   = 1'b1;
                    next_state = st_refill_req;
                end
            end
            st_refill_req: begin
                refill_start = 1'b1;
                next_state   = st_refill_wait;
            end
            st_refill_wait: begin
                if (refill_done) begin
                    next_state = st_fill;
                end
            end
            st_fill: begin
                fill_we    = 1'b1;
                next_state = st_fill_done;
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // refilled line is held until st_fill
    always_ff @(posedge clk) begin
        if (refill_done) begin
            fill_buf     <= fill_line;
            fill_dirty_q <= fill_dirty;
        end
    end

    // burst completions only arrive while the matching wait state stalls the cpu
    a_refill_done: assert property (@(posedge clk) disable iff (!resetn)
        refill_done |-> (state == st_refill_wait));

    a_wb_done: assert property (@(posedge clk) disable iff (!resetn)
        wb_done |-> (state == st_wb_wait));

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/1ns
module dcache_top
    import dcache_pkg::*;
#(
    parameter int  index_bits    = def_index_bits,
    parameter int  word_off_bits = def_word_off_bits,
    localparam int tag_bits      = 30 - index_bits - word_off_bits,
    localparam int line_bits     = 32 << word_off_bits
) (
    input  logic     clk,
    input  logic     resetn,
    input  cpu_req_t req,
    output logic     stall,
    output word_t    rdata,
    output addr_t    ar_addr,
    output logic     ar_valid,
    input  logic     ar_ready,
    input  mem_rd_t  rd,
    output addr_t    aw_addr,
    output logic     aw_valid,
    input  logic     aw_ready,
    output word_t    w_data,
    output logic     w_valid,
    output logic     w_last,
    input  logic     b_valid
);

    // controller to line store
    logic [index_bits-1:0]    index;
    logic                     word_we;
    logic [word_off_bits-1:0] word_off;
    word_t                    word_data;
    strb_t                    word_strb;
    logic                     fill_we;
    logic [tag_bits-1:0]      fill_tag;
    logic [line_bits-1:0]     fill_data;
    logic                     fill_dirty_bit;
    logic                     clean_we;

    // line store read port
    logic [tag_bits-1:0]      rd_tag;
    logic                     rd_valid;
    logic                     rd_dirty;
    logic [line_bits-1:0]     rd_line;

    // controller and burst port
    logic                     refill_start;
    logic                     wb_start;
    addr_t                    line_addr;
    logic                     merge_en;
    logic [word_off_bits-1:0] merge_off;
    word_t                    merge_data;
    strb_t                    merge_strb;
    logic                     refill_done;
    logic [line_bits-1:0]     fill_line;
    logic                     fill_dirty;
    logic                     wb_done;

    dcache_ctrl #(
        .index_bits    (index_bits),
        .word_off_bits (word_off_bits)
    ) dcache_ctrl_inst (.*);

    dcache_line_store #(
        .index_bits    (index_bits),
        .word_off_bits (word_off_bits)
    ) dcache_line_store_inst (.*);

    // victim line is read straight from the store
    line_burst_port #(
        .word_off_bits (word_off_bits)
    ) line_burst_port_inst (
        .wb_line (rd_line),
        .*
    );

endmodule

/* testbench/axi_mem_slave.sv */
`timescale 1ns/1ns
module axi_mem_slave
    import dcache_pkg::*;
#(
    parameter addr_t mem_base  = 32'h0001_0000,
    parameter int    mem_words = 256,
    parameter int    seed_init = 4478
) (
    input  logic    clk,
    input  logic    resetn,
    input  addr_t   ar_addr,
    input  logic    ar_valid,
    output logic    ar_ready,
    output mem_rd_t rd,
    input  addr_t   aw_addr,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  word_t   w_data,
    input  logic    w_valid,
    input  logic    w_last,
    output logic    b_valid,
    output int      ar_count,
    output int      aw_count,
    output addr_t   last_ar_addr,
    output addr_t   last_aw_addr,
    output logic    last_was_write,
    output int      proto_errors
);

    word_t  mem [mem_words];
    integer seed;
    int     r_base;
    int     r_left;
    int     w_base;
    int     w_cnt;
    logic   w_active;

    function automatic word_t init_pattern(input addr_t a);
        return a * 32'h9e37_79b1 + 32'h1234_5678;
    endfunction

    function automatic int word_index(input addr_t a);
        return ((a - mem_base) >> 2) & (mem_words - 1);
    endfunction

    // 16-byte lines inside the backing array
    function automatic logic line_ok(input addr_t a);
        return (a[3:0] == 4'h0) && (a >= mem_base) && (a < mem_base + 4 * mem_words);
    endfunction

    initial begin
        seed           = seed_init;
        ar_ready       = 1'b0;
        aw_ready       = 1'b0;
        rd             = '0;
        b_valid        = 1'b0;
        ar_count       = 0;
        aw_count       = 0;
        last_ar_addr   = '0;
        last_aw_addr   = '0;
        last_was_write = 1'b0;
        proto_errors   = 0;
        r_left         = 0;
        w_active       = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = init_pattern(mem_base + 4 * i);
        end
    end

    always @(posedge clk) begin
        if (!resetn) begin
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            rd       <= '0;
            b_valid  <= 1'b0;
            r_left   <= 0;
            w_active <= 1'b0;
        end else begin
            // ready comes after a random delay and drops on the handshake
            if (ar_valid && ar_ready) begin
                assert (line_ok(ar_addr)) else begin
                    proto_errors++;
                    $display("slave: misaligned or out of range read address %h", ar_addr);
                end
                ar_ready       <= 1'b0;
                r_base         <= word_index(ar_addr);
                r_left         <= 4;
                ar_count       <= ar_count + 1;
                last_ar_addr   <= ar_addr;
                last_was_write <= 1'b0;
            end else begin
                ar_ready <= ar_valid && (($random(seed) & 3) == 0);
            end
            rd <= '0;
            if (r_left != 0) begin
                rd.r_data  <= mem[(r_base + 4 - r_left) & (mem_words - 1)];
                rd.r_valid <= 1'b1;
                rd.r_last  <= (r_left == 1);
                r_left     <= r_left - 1;
            end
            b_valid <= 1'b0;
            if (aw_valid && aw_ready) begin
                assert (line_ok(aw_addr)) else begin
                    proto_errors++;
                    $display("slave: misaligned or out of range write address %h", aw_addr);
                end
                aw_ready       <= 1'b0;
                w_active       <= 1'b1;
                w_base         <= word_index(aw_addr);
                w_cnt          <= 0;
                aw_count       <= aw_count + 1;
                last_aw_addr   <= aw_addr;
                last_was_write <= 1'b1;
            end else begin
                aw_ready <= aw_valid && (($random(seed) & 3) == 0);
            end
            if (w_valid) begin
                assert (w_active) else begin
                    proto_errors++;
                    $display("slave: write beat arrived outside a burst");
                end
                assert (w_last == (w_cnt == 3)) else begin
                    proto_errors++;
                    $display("slave: write burst length is not 4 beats");
                end
                mem[(w_base + w_cnt) & (mem_words - 1)] <= w_data;
                w_cnt <= w_cnt + 1;
                if (w_last) begin
                    w_active <= 1'b0;
                    b_valid  <= 1'b1;
                end
            end
        end
    end

endmodule

/* testbench/dcache_tb.sv */
`timescale 1ns/1ns
module dcache_tb
    import dcache_pkg::*;
();

    localparam addr_t mem_base          = 32'h0001_0000;
    localparam int    mem_words         = 256;
    localparam int    num_ops           = 300;
    // writeback plus refill with slow ready, rounded up
    localparam int    worst_miss_cycles = 40;
    // each write may be followed by a read back, plus the sweep
    localparam int    timeout_cycles    = (2 * num_ops + 32) * worst_miss_cycles + 1000;

    logic     clk;
    logic     resetn;
    cpu_req_t req;
    logic     stall;
    word_t    rdata;
    addr_t    ar_addr;
    logic     ar_valid;
    logic     ar_ready;
    mem_rd_t  rd;
    addr_t    aw_addr;
    logic     aw_valid;
    logic     aw_ready;
    word_t    w_data;
    logic     w_valid;
    logic     w_last;
    logic     b_valid;
    int       ar_count;
    int       aw_count;
    addr_t    last_ar_addr;
    addr_t    last_aw_addr;
    logic     last_was_write;
    int       proto_errors;

    word_t       model [mem_words];
    logic [23:0] m_tag [16];
    logic        m_valid [16];
    logic        m_dirty [16];
    integer      seed;
    int          errors;
    int          cycle_count;

    dcache_top dcache_top_inst (.*);

    axi_mem_slave #(
        .mem_base  (mem_base),
        .mem_words (mem_words),
        .seed_init (4478)
    ) mem_slave_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic word_t mem_pattern(input addr_t a);
        return a * 32'h9e37_79b1 + 32'h1234_5678;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8 * b +: 8] = data[8 * b +: 8];
        end
        return res;
    endfunction

    // tag select in bits 9:8, line in 7:4, word in 3:2
    function automatic addr_t make_addr(input int tsel, input int line, input int word);
        return mem_base + (tsel << 8) + (line << 4) + (word << 2);
    endfunction

    task automatic expect_equal(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic hold_idle(input int cycles);
        @(negedge clk);
        req.op = op_none;
        repeat (cycles) begin
            @(negedge clk);
            assert (!stall && !ar_valid && !aw_valid && !w_valid) else begin
                errors++;
                $display("idle: stall or a bus valid went high without a request");
            end
        end
    endtask

    task automatic run_op(input cpu_op_t op, input addr_t addr, input word_t data,
                          input strb_t strb, output logic was_hit);
        int    line;
        int    widx;
        int    vidx;
        int    n;
        int    ar0;
        int    aw0;
        logic  evict;
        addr_t victim;
        line    = addr[7:4];
        widx    = (addr - mem_base) >> 2;
        was_hit = m_valid[line] && (m_tag[line] == addr[31:8]);
        evict   = !was_hit && m_valid[line] && m_dirty[line];
        victim  = {m_tag[line], addr[7:4], 4'h0};
        vidx    = (victim - mem_base) >> 2;
        ar0     = ar_count;
        aw0     = aw_count;
        @(negedge clk);
        req.op    = op;
        req.addr  = addr;
        req.wdata = data;
        req.strb  = strb;
        n = 2;
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
            n++;
        end
        if (op == op_read) begin
            expect_equal("read_data", model[widx], rdata);
        end
        if (was_hit) begin
            expect_equal("hit_latency", (op == op_read) ? 2 : 3, n);
            expect_equal("hit_bus_traffic", ar0 + aw0, ar_count + aw_count);
        end else begin
            expect_equal("refill_bursts", ar0 + 1, ar_count);
            expect_equal("refill_addr", {addr[31:4], 4'h0}, last_ar_addr);
            expect_equal("writeback_bursts", aw0 + evict, aw_count);
        end
        if (evict) begin
            assert (!last_was_write) else begin
                errors++;
                $display("eviction: write burst did not come before the read burst");
            end
            expect_equal("victim_addr", victim, last_aw_addr);
            for (int k = 0; k < 4; k++) begin
                expect_equal("victim_line", model[vidx + k], mem_slave_inst.mem[vidx + k]);
            end
        end
        if (op == op_write) begin
            model[widx] = merge_bytes(model[widx], data, strb);
        end
        // direct-mapped mirror
        if (!was_hit) begin
            m_tag[line]   = addr[31:8];
            m_valid[line] = 1'b1;
            m_dirty[line] = 1'b0;
        end
        if (op == op_write) m_dirty[line] = 1'b1;
    endtask

    initial begin
        logic  hit;
        int    r;
        addr_t addr;
        seed        = 4478;
        errors      = 0;
        cycle_count = 0;
        clk         = 1'b0;
        resetn      = 1'b0;
        req         = '0;
        for (int i = 0; i < mem_words; i++) begin
            model[i] = mem_pattern(mem_base + 4 * i);
        end
        for (int i = 0; i < 16; i++) begin
            m_tag[i]   = '0;
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        hold_idle(8);
        repeat (num_ops) begin
            r    = $random(seed);
            addr = make_addr($random(seed) & 3, $random(seed) & 15, $random(seed) & 3);
            if ((r & 7) == 0) begin
                hold_idle(1 + ((r >> 3) & 3));
            end else if ((r & 7) < 5) begin
                run_op(op_read, addr, '0, '0, hit);
            end else begin
                run_op(op_write, addr, $random(seed), $random(seed) & 15, hit);
                // write miss merged into the refill, read it back
                if (!hit) run_op(op_read, addr, '0, '0, hit);
            end
        end
        // a conflicting read at every line flushes all dirty data
        for (int i = 0; i < 16; i++) begin
            addr = make_addr(0, i, 0);
            if (m_valid[i] && m_tag[i] == addr[31:8]) addr = make_addr(1, i, 0);
            run_op(op_read, addr, '0, '0, hit);
        end
        for (int i = 0; i < mem_words; i++) begin
            expect_equal("final_memory", model[i], mem_slave_inst.mem[i]);
        end
        hold_idle(8);
        $display("errors: %0d checks, %0d slave protocol", errors, proto_errors);
        if (errors == 0 && proto_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/dcache_pkg.sv
verilog/dcache_line_store.sv
verilog/line_burst_port.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
testbench/axi_mem_slave.sv
testbench/dcache_tb.sv
